// File: testbench/outputPort_testdata.txt
# test(dec) req lFlit nFlit eFlit wFlit sFlit expGrant expValid expOutFlit, all but test in hex
# expected columns are the outputs late in the cycle, registered from the line before
1 00 0000 0000 0000 0000 0000 00 0 0000
1 00 0000 0000 0000 0000 0000 00 0 0000
2 1e 0000 4202 4302 4402 4502 00 0 0000
2 00 0000 0000 0000 0000 0000 02 0 0000
2 1c 0000 0000 4304 4404 4504 00 0 0000
2 1c 0000 0000 4305 4405 4505 04 0 0000
2 00 0000 0000 0000 0000 0000 08 1 4305
3 01 2002 0000 0000 0000 0000 00 0 0000
3 01 4108 0000 0000 0000 0000 01 0 0000
3 01 4109 0000 0000 0000 0000 01 1 4108
3 01 410a 0000 0000 0000 0000 01 1 4109
3 01 410b 0000 0000 0000 0000 00 1 410a
3 00 0000 0000 0000 0000 0000 01 0 0000
4 08 0000 0000 0000 2001 0000 00 0 0000
4 1a 0000 420e 0000 440e 2000 08 0 0000
4 1a 0000 420f 0000 440f 450f 08 1 440e
4 1a 0000 4210 0000 4410 4510 10 1 440f
4 00 0000 0000 0000 0000 0000 02 1 4510
4 00 0000 0000 0000 0000 0000 00 0 0000
5 04 0000 0000 2005 0000 0000 00 0 0000
5 05 4114 0000 4314 0000 0000 04 0 0000
5 01 4115 0000 0000 0000 0000 04 1 4314
5 00 0000 0000 0000 0000 0000 01 0 0000
5 00 0000 0000 0000 0000 0000 00 0 0000

// File: project.f
design/nocPkg.sv
design/flitDecoder.sv
design/grantTimer.sv
design/portArbiter.sv
design/outputCrossbar.sv
design/routerOutputPort.sv
testbench/tbRouterOutputPort.sv

// File: Makefile
# Verilator build and run of the router output port testbench

VERILATOR ?= verilator
TOP       ?= tbRouterOutputPort
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tbRouterOutputPort.sv
`timescale 1ns/1ps
`default_nettype none

module tbRouterOutputPort;

  localparam int clkHalf = 2; // 4 ns period.
  localparam int driveDelay = 1;
  localparam int checkDelay = 2; // lands 1 ns before the next edge.
  localparam int resetCycles = 3;
  localparam int maxLines = 64;
  localparam int expectedLines = 24;
  localparam int maxCycles = 200;

  logic             clk;
  logic             rst;
  nocPkg::portMaskT req;
  nocPkg::flitWordT lFlit;
  nocPkg::flitWordT nFlit;
  nocPkg::flitWordT eFlit;
  nocPkg::flitWordT wFlit;
  nocPkg::flitWordT sFlit;
  nocPkg::portMaskT grant;
  logic             outValid;
  nocPkg::flitWordT outFlit;

  int testErrors;
  int testsPassed;
  int testsFailed;
  int otherFailures;
  bit done;

  routerOutputPort i_dut (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .grant    (grant),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

  initial
  begin
    clk = 1'b0;
    forever #clkHalf clk = ~clk;
  end

  task automatic checkValue(input string name, input logic [15:0] expected,
                            input logic [15:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL t=%0t ns %s expected %h got %h", $time, name, expected, actual);
      testErrors++;
    end
  endtask

  task automatic finishTest(input int testNum, input int cycles);
    if (testErrors == 0)
    begin
      testsPassed++;
      $display("test %0d: ok over %0d cycles", testNum, cycles);
    end
    else
    begin
      testsFailed++;
      $display("test %0d: %0d mismatches over %0d cycles", testNum, testErrors, cycles);
    end
    testErrors = 0;
  endtask

  // stops a run that never reaches its end
  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (!done && cycles < maxCycles)
    begin
      @(posedge clk);
      cycles++;
    end
    if (!done)
    begin
      $display("ERROR: run did not finish within %0d cycles", maxCycles);
      $display("Test failed");
      $finish;
    end
  end

  initial
  begin : stimulus
    int          fd;
    int          lineCount;
    int          dataLines;
    int          items;
    int          testNum;
    int          currentTest;
    int          testCycles;
    string       text;
    logic [15:0] reqIn;
    logic [15:0] lIn;
    logic [15:0] nIn;
    logic [15:0] eIn;
    logic [15:0] wIn;
    logic [15:0] sIn;
    logic [15:0] expGrant;
    logic [15:0] expValid;
    logic [15:0] expFlit;

    done = 1'b0;
    rst = 1'b1;
    req = '0;
    lFlit = '0;
    nFlit = '0;
    eFlit = '0;
    wFlit = '0;
    sFlit = '0;
    testErrors = 0;
    testsPassed = 0;
    testsFailed = 0;
    otherFailures = 0;
    lineCount = 0;
    dataLines = 0;
    testCycles = 0;
    currentTest = -1;

    fd = $fopen("testbench/outputPort_testdata.txt", "r");
    if (fd == 0)
    begin
      $display("ERROR: cannot open the test data file");
      otherFailures++;
    end

    for (int i = 0; i < resetCycles; i++)
      @(posedge clk);
    #driveDelay;
    rst = 1'b0; // first data line goes in with the release.

    while (fd != 0 && !$feof(fd) && lineCount < maxLines)
    begin
      lineCount++;
      text = "";
      items = $fgets(text, fd);
      if (items == 0 || text.len() < 2 || text[0] == "#")
        continue; // blank or comment.
      items = $sscanf(text, "%d %h %h %h %h %h %h %h %h %h", testNum, reqIn,
                      lIn, nIn, eIn, wIn, sIn, expGrant, expValid, expFlit);
      if (items != 10)
      begin
        $display("ERROR: data line %0d has %0d fields instead of 10", lineCount, items);
        otherFailures++;
        continue;
      end
      if (testNum != currentTest)
      begin
        if (currentTest >= 0)
          finishTest(currentTest, testCycles);
        currentTest = testNum;
        testCycles = 0;
      end
      if (dataLines > 0)
      begin
        @(posedge clk);
        #driveDelay;
      end
      req = reqIn[4:0];
      lFlit = lIn;
      nFlit = nIn;
      eFlit = eIn;
      wFlit = wIn;
      sFlit = sIn;
      #checkDelay;
      // registered outputs still hold what the edge before captured
      checkValue("grant", expGrant, {11'b0, grant});
      checkValue("outValid", expValid, {15'b0, outValid});
      checkValue("outFlit", expFlit, outFlit);
      dataLines++;
      testCycles++;
    end

    if (currentTest >= 0)
      finishTest(currentTest, testCycles);
    if (fd != 0 && lineCount >= maxLines && !$feof(fd))
    begin
      $display("ERROR: line limit of %0d reached before the end of the data file", maxLines);
      otherFailures++;
    end
    if (fd != 0 && dataLines != expectedLines)
    begin
      $display("ERROR: data file ended after %0d of %0d cycles", dataLines, expectedLines);
      otherFailures++;
    end
    if (fd != 0)
      $fclose(fd);

    done = 1'b1;
    $display("tests passed: %0d, tests failed: %0d, other errors: %0d",
             testsPassed, testsFailed, otherFailures);
    if (testsFailed == 0 && otherFailures == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/routerOutputPort.sv
`timescale 1ns/1ps
`default_nettype none

module routerOutputPort (
  input  wire                   clk,
  input  wire                   rst,
  input  wire nocPkg::portMaskT req,
  input  wire nocPkg::flitWordT lFlit,
  input  wire nocPkg::flitWordT nFlit,
  input  wire nocPkg::flitWordT eFlit,
  input  wire nocPkg::flitWordT wFlit,
  input  wire nocPkg::flitWordT sFlit,
  output nocPkg::portMaskT      grant,
  output logic                  outValid,
  output nocPkg::flitWordT      outFlit
);

  nocPkg::budgetT lBudget;
  nocPkg::budgetT nBudget;
  nocPkg::budgetT eBudget;
  nocPkg::budgetT wBudget;
  nocPkg::budgetT sBudget;

  flitDecoder i_decoder (
    .clk     (clk),
    .rst     (rst),
    .lFlit   (lFlit),
    .nFlit   (nFlit),
    .eFlit   (eFlit),
    .wFlit   (wFlit),
    .sFlit   (sFlit),
    .lBudget (lBudget),
    .nBudget (nBudget),
    .eBudget (eBudget),
    .wBudget (wBudget),
    .sBudget (sBudget)
  );

  portArbiter i_arbiter (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .lBudget (lBudget),
    .nBudget (nBudget),
    .eBudget (eBudget),
    .wBudget (wBudget),
    .sBudget (sBudget),
    .grant   (grant)
  );

  outputCrossbar i_crossbar (
    .clk      (clk),
    .rst      (rst),
    .grant    (grant),
    .req      (req),
    .lFlit    (lFlit),
    .nFlit    (nFlit),
    .eFlit    (eFlit),
    .wFlit    (wFlit),
    .sFlit    (sFlit),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

endmodule

`default_nettype wire

// File: design/outputCrossbar.sv
`timescale 1ns/1ps
`default_nettype none

module outputCrossbar (
  input  wire                   clk,
  input  wire                   rst,
  input  wire nocPkg::portMaskT grant,
  input  wire nocPkg::portMaskT req,
  input  wire nocPkg::flitWordT lFlit,
  input  wire nocPkg::flitWordT nFlit,
  input  wire nocPkg::flitWordT eFlit,
  input  wire nocPkg::flitWordT wFlit,
  input  wire nocPkg::flitWordT sFlit,
  output logic                  outValid,
  output nocPkg::flitWordT      outFlit
);

  nocPkg::flitWordT flit [nocPkg::numPorts];
  nocPkg::flitWordT selFlit;
  logic             selValid;

  assign flit[0] = lFlit;
  assign flit[1] = nFlit;
  assign flit[2] = eFlit;
  assign flit[3] = wFlit;
  assign flit[4] = sFlit;

  always_comb
  begin
    selFlit = '0; // zero when nothing is granted.
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (grant[i])
        selFlit = selFlit | flit[i];
    end
    selValid = (grant & req) != '0;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outFlit  <= '0;
    end
    else
    begin
      outValid <= selValid;
      outFlit  <= selFlit;
    end
  end

  aValidNeedsGrant: assert property (
    @(posedge clk) disable iff (rst) outValid |-> $past(grant) != '0
  );

endmodule

`default_nettype wire

// File: design/portArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module portArbiter (
  input  wire                   clk,
  input  wire                   rst,
  input  wire nocPkg::portMaskT req,
  input  wire nocPkg::budgetT   lBudget,
  input  wire nocPkg::budgetT   nBudget,
  input  wire nocPkg::budgetT   eBudget,
  input  wire nocPkg::budgetT   wBudget,
  input  wire nocPkg::budgetT   sBudget,
  output nocPkg::portMaskT      grant
);

  nocPkg::arbStateT state;
  nocPkg::arbStateT nextState;
  nocPkg::budgetT   budget [nocPkg::numPorts];
  nocPkg::portMaskT runTimer;
  wire nocPkg::portMaskT timesUp;
  nocPkg::portMaskT pick;
  int               holderIdx;

  // first set bit of mask, searching cyclically from start
  function automatic nocPkg::portMaskT firstFrom(input nocPkg::portMaskT mask,
                                                  input int start);
    nocPkg::portMaskT found;
    int idx;
    found = '0;
    for (int k = 0; k < nocPkg::numPorts; k++)
    begin
      idx = (start + k) % nocPkg::numPorts;
      if (mask[idx] && (found == '0))
        found[idx] = 1'b1;
    end
    return found;
  endfunction

  assign budget[0] = lBudget;
  assign budget[1] = nBudget;
  assign budget[2] = eBudget;
  assign budget[3] = wBudget;
  assign budget[4] = sBudget;

  for (genvar i = 0; i < nocPkg::numPorts; i++)
  begin : gTimer
    grantTimer i_timer (
      .clk      (clk),
      .rst      (rst),
      .budget   (budget[i]),
      .runTimer (runTimer[i]),
      .timesUp  (timesUp[i])
    );
  end

  assign grant = state[nocPkg::numPorts:1]; // drop the idle bit.

  always_comb
  begin
    holderIdx = 0;
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (grant[i])
        holderIdx = i;
    end
  end

  always_comb
  begin
    runTimer = '0;
    if (state == nocPkg::arbIdle)
      pick = firstFrom(req, 0); // fixed priority, local first.
    else if (req[holderIdx] && !timesUp[holderIdx])
    begin
      pick = grant;
      runTimer = grant;
    end
    else
      pick = firstFrom(req & ~grant, holderIdx + 1); // rotate past the holder.
    nextState = nocPkg::arbStateT'({pick, pick == '0});
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      state <= nocPkg::arbIdle;
    else
      state <= nextState;
  end

  aStateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state));

  // a new grant must go to a port that was requesting when it was decided
  aGrantToRequester: assert property (
    @(posedge clk) disable iff (rst)
    (grant != '0) && (grant != $past(grant)) |-> (grant & $past(req)) == grant
  );

endmodule

`default_nettype wire

// File: design/grantTimer.sv
`timescale 1ns/1ps
`default_nettype none

module grantTimer (
  input  wire                 clk,
  input  wire                 rst,
  input  wire nocPkg::budgetT budget,
  input  wire                 runTimer,
  output logic                timesUp
);

  nocPkg::budgetT count;

  always_ff @(posedge clk)
  begin
    if (rst)
      count <= '0;
    else if (runTimer)
      count <= count + 1'b1;
    else
      count <= '0; // grant released or not yet held.
  end

  // a budget of zero expires in the first grant cycle
  assign timesUp = (count == budget);

  // the arbiter must drop runTimer once the count reaches the budget
  aCountInBudget: assert property (
    @(posedge clk) disable iff (rst) runTimer |-> count <= budget
  );

endmodule

`default_nettype wire

// File: design/flitDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module flitDecoder (
  input  wire                clk,
  input  wire                rst,
  input  wire nocPkg::flitWordT lFlit,
  input  wire nocPkg::flitWordT nFlit,
  input  wire nocPkg::flitWordT eFlit,
  input  wire nocPkg::flitWordT wFlit,
  input  wire nocPkg::flitWordT sFlit,
  output nocPkg::budgetT     lBudget,
  output nocPkg::budgetT     nBudget,
  output nocPkg::budgetT     eBudget,
  output nocPkg::budgetT     wBudget,
  output nocPkg::budgetT     sBudget
);

  nocPkg::flitWordT flit [nocPkg::numPorts];
  nocPkg::flitTypeT flitType [nocPkg::numPorts];
  nocPkg::budgetT   budget [nocPkg::numPorts];
  nocPkg::portMaskT isHeader;
  nocPkg::portMaskT badType;

  assign flit[0] = lFlit;
  assign flit[1] = nFlit;
  assign flit[2] = eFlit;
  assign flit[3] = wFlit;
  assign flit[4] = sFlit;

  always_comb
  begin
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      flitType[i] = flit[i][nocPkg::flitWidth-1 -: nocPkg::typeWidth];
      isHeader[i] = (flitType[i] == nocPkg::headerType); // request level not needed.
      // an idle link carries all zeros
      badType[i] = (flit[i] != '0) && (flitType[i] == nocPkg::reservedType);
    end
  end

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < nocPkg::numPorts; i++)
    begin
      if (rst)
        budget[i] <= '0;
      else if (isHeader[i])
        budget[i] <= flit[i][nocPkg::budgetWidth-1:0]; // packet length.
    end
  end

  assign lBudget = budget[0];
  assign nBudget = budget[1];
  assign eBudget = budget[2];
  assign wBudget = budget[3];
  assign sBudget = budget[4];

  aNoReservedType: assert property (@(posedge clk) disable iff (rst) badType == '0);

endmodule

`default_nettype wire

// File: design/nocPkg.sv
`default_nettype none

package nocPkg;

  localparam int numPorts = 5; // local, north, east, west, south.
  localparam int flitWidth = 16;
  localparam int typeWidth = 3;
  localparam int budgetWidth = 12; // length field of a header.

  typedef logic [flitWidth-1:0] flitWordT;
  typedef logic [typeWidth-1:0] flitTypeT;
  typedef logic [budgetWidth-1:0] budgetT;
  typedef logic [numPorts-1:0] portMaskT; // bit 0 local up to bit 4 south.

  localparam flitTypeT reservedType = 3'd0; // never sent on a live link.
  localparam flitTypeT headerType = 3'd1;

  // bit 0 is idle, the port states follow in mask order
  typedef enum logic [numPorts:0] {
    arbIdle  = 6'b000001,
    arbLocal = 6'b000010,
    arbNorth = 6'b000100,
    arbEast  = 6'b001000,
    arbWest  = 6'b010000,
    arbSouth = 6'b100000
  } arbStateT;

endpackage

`default_nettype wire
